//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_conv_engine
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -E '\.s?v$$' $(FLIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx 'TB PASSED' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
rtl/conv_pkg.sv
rtl/frame_if.sv
rtl/frame_loader.sv
rtl/conv.sv
rtl/slide_window_conv.sv
rtl/result_drain.sv
rtl/conv_engine_top.sv
verif/conv_engine_assert.sv
verif/tb_conv_engine.sv

//--- rtl/conv.sv
`timescale 1ns/1ps

module conv
    import conv_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [n_taps-1:0][data_w-1:0] window,
    input  logic [n_taps-1:0][data_w-1:0] weights,
    output logic [data_w-1:0]             result,
    output logic                          done
);

    logic                       running;
    logic                       sat_pend;  // taps finished, saturate next
    logic [tap_w-1:0]           tap;
    logic signed [acc_w-1:0]    acc;
    logic signed [2*data_w-1:0] prod;
    logic                       fits;
    logic [data_w-1:0]          sat_val;

    assign prod = $signed(window[tap]) * $signed(weights[tap]);

    // in range when all bits above the sign bit match it
    assign fits    = (acc[acc_w-1:data_w-1] == {(acc_w-data_w+1){acc[acc_w-1]}});
    assign sat_val = fits ? acc[data_w-1:0] :
                     acc[acc_w-1] ? {1'b1, {(data_w-1){1'b0}}} :
                                    {1'b0, {(data_w-1){1'b1}}};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running  <= 1'b0;
            sat_pend <= 1'b0;
            tap      <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                running <= 1'b1;
                tap     <= '0;
            end
            else if (running)
            begin
                if (tap == tap_w'(n_taps - 1))
                begin
                    running  <= 1'b0;
                    sat_pend <= 1'b1;
                end
                else
                begin
                    tap <= tap + tap_w'(1);
                end
            end
            else if (sat_pend)
            begin
                sat_pend <= 1'b0;
                done     <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
            acc <= '0;
        else if (running)
            acc <= acc + {{(acc_w-2*data_w){prod[2*data_w-1]}}, prod};  // sign extend
        if (sat_pend)
            result <= sat_val;
    end

endmodule

//--- rtl/conv_engine_top.sv
`timescale 1ns/1ps

module conv_engine_top
    import conv_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  logic [31:0]       in_word,
    output logic              in_ready,
    output logic              out_valid,
    output logic [data_w-1:0] out_data,
    input  logic              credit_return
);

    logic [n_windows-1:0][data_w-1:0] results;
    logic                             results_valid;
    logic                             results_taken;

    frame_if fr_if ();  // loader to window engine

    frame_loader frame_loader_inst (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_word  (in_word),
        .in_ready (in_ready),
        .fr       (fr_if.loader)
    );

    slide_window_conv slide_window_conv_inst (
        .clk           (clk),
        .rst           (rst),
        .fr            (fr_if.engine),
        .results       (results),
        .results_valid (results_valid),
        .results_taken (results_taken)
    );

    result_drain result_drain_inst (
        .clk           (clk),
        .rst           (rst),
        .results       (results),
        .results_valid (results_valid),
        .results_taken (results_taken),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .credit_return (credit_return)
    );

endmodule

//--- rtl/conv_pkg.sv
package conv_pkg;

    localparam int img_rows    = 5;
    localparam int img_cols    = 5;
    localparam int pad         = 1;
    localparam int flt_rows    = 3;
    localparam int flt_cols    = 3;
    localparam int out_rows    = 3;
    localparam int out_cols    = 3;
    localparam int n_windows   = out_rows * out_cols;
    localparam int n_taps      = flt_rows * flt_cols;
    localparam int img_pixels  = img_rows * img_cols;
    localparam int pad_rows    = img_rows + 2 * pad;  // 7x7 padded frame
    localparam int pad_cols    = img_cols + 2 * pad;

    localparam int data_w      = 16;
    localparam int acc_w       = 36;  // nine 32-bit products with headroom
    localparam int out_credits = 4;

    localparam int word_cnt_w  = 4;
    localparam int smp_idx_w   = 5;
    localparam int tap_w       = 4;
    localparam int res_idx_w   = 4;
    localparam int cred_w      = 3;

    localparam logic [3:0] op_image  = 4'h1;
    localparam logic [3:0] op_filter = 4'h2;
    localparam logic [3:0] op_run    = 4'h3;

    localparam logic [word_cnt_w-1:0] img_words = 4'd13;  // 25 samples, two per word
    localparam logic [word_cnt_w-1:0] flt_words = 4'd5;   // 9 samples

    typedef struct packed {
        logic [3:0]  op;
        logic [27:0] rsvd;
    } load_hdr_t;

    typedef struct packed {
        logic [15:0] sample_hi;
        logic [15:0] sample_lo;  // first sample of the pair
    } load_data_t;

    typedef union packed {
        load_hdr_t  hdr;
        load_data_t data;
    } load_word_u;

endpackage

//--- rtl/frame_if.sv
`timescale 1ns/1ps

interface frame_if
    import conv_pkg::*;
();

    logic [img_pixels-1:0][data_w-1:0] image;   // row-major pixels
    logic [n_taps-1:0][data_w-1:0]     filter;  // row-major weights
    logic                              frame_valid;
    logic                              frame_taken;

    modport loader (
        output image,
        output filter,
        output frame_valid,
        input  frame_taken
    );

    modport engine (
        input  image,
        input  filter,
        input  frame_valid,
        output frame_taken
    );

endinterface

//--- rtl/frame_loader.sv
`timescale 1ns/1ps

module frame_loader
    import conv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  load_word_u in_word,
    output logic       in_ready,
    frame_if.loader    fr
);

    logic                  accept;
    logic                  in_header;  // idle, next word is a header
    logic [word_cnt_w-1:0] rem_cnt;    // data words still expected
    logic [smp_idx_w-1:0]  sidx;       // index of the low sample
    logic [smp_idx_w-1:0]  sidx_hi;
    logic                  to_filter;  // data goes to filter, else image

    // buffers locked while a frame is pending
    assign in_ready  = !fr.frame_valid;
    assign accept    = in_valid && in_ready;
    assign in_header = (rem_cnt == '0);
    assign sidx_hi   = sidx + smp_idx_w'(1);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rem_cnt        <= '0;
            sidx           <= '0;
            to_filter      <= 1'b0;
            fr.frame_valid <= 1'b0;
        end
        else
        begin
            if (fr.frame_taken)
            begin
                fr.frame_valid <= 1'b0;  // engine has handed off the set
            end
            if (accept)
            begin
                if (in_header)
                begin
                    case (in_word.hdr.op)
                        op_image:
                        begin
                            rem_cnt   <= img_words;
                            sidx      <= '0;
                            to_filter <= 1'b0;
                        end
                        op_filter:
                        begin
                            rem_cnt   <= flt_words;
                            sidx      <= '0;
                            to_filter <= 1'b1;
                        end
                        op_run:
                        begin
                            fr.frame_valid <= 1'b1;
                        end
                        default:
                        begin
                            rem_cnt <= '0;  // unknown header dropped
                        end
                    endcase
                end
                else
                begin
                    rem_cnt <= rem_cnt - word_cnt_w'(1);
                    sidx    <= sidx + smp_idx_w'(2);
                end
            end
        end
    end

    // sample pair write, high half dropped past the end
    always_ff @(posedge clk)
    begin
        if (accept && !in_header)
        begin
            if (to_filter)
            begin
                if (sidx < n_taps)
                    fr.filter[sidx] <= in_word.data.sample_lo;
                if (sidx_hi < n_taps)
                    fr.filter[sidx_hi] <= in_word.data.sample_hi;
            end
            else
            begin
                if (sidx < img_pixels)
                    fr.image[sidx] <= in_word.data.sample_lo;
                if (sidx_hi < img_pixels)
                    fr.image[sidx_hi] <= in_word.data.sample_hi;
            end
        end
    end

endmodule

//--- rtl/result_drain.sv
`timescale 1ns/1ps

module result_drain
    import conv_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic [n_windows-1:0][data_w-1:0] results,
    input  logic                             results_valid,
    output logic                             results_taken,
    output logic                             out_valid,
    output logic [data_w-1:0]                out_data,
    input  logic                             credit_return
);

    logic [n_windows-1:0][data_w-1:0] set_buf;
    logic                             full;     // set held, not yet fully sent
    logic [res_idx_w-1:0]             rd_idx;
    logic [cred_w-1:0]                credits;
    logic                             emit;

    assign results_taken = results_valid && !full;
    assign emit          = full && (credits != '0);
    assign out_valid     = emit;
    assign out_data      = set_buf[rd_idx];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            full    <= 1'b0;
            rd_idx  <= '0;
            credits <= cred_w'(out_credits);
        end
        else
        begin
            if (results_taken)
            begin
                full   <= 1'b1;
                rd_idx <= '0;
            end
            if (emit)
            begin
                rd_idx <= rd_idx + res_idx_w'(1);
                if (rd_idx == res_idx_w'(n_windows - 1))
                    full <= 1'b0;  // last result of the set
            end

            // spend and return may meet in one cycle
            case ({emit, credit_return})
                2'b10:   credits <= credits - cred_w'(1);
                2'b01:   credits <= credits + cred_w'(1);
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (results_taken)
            set_buf <= results;
    end

endmodule

//--- rtl/slide_window_conv.sv
`timescale 1ns/1ps

module slide_window_conv
    import conv_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    frame_if.engine                          fr,
    output logic [n_windows-1:0][data_w-1:0] results,
    output logic                             results_valid,
    input  logic                             results_taken
);

    logic [pad_rows-1:0][pad_cols-1:0][data_w-1:0] padded;
    logic [n_windows-1:0][n_taps-1:0][data_w-1:0]  windows;
    logic [n_windows-1:0][data_w-1:0]              unit_result;
    logic [n_windows-1:0]                          unit_done;
    logic                                          busy;
    logic                                          start;

    // zero border around the image
    for (genvar r = 0; r < pad_rows; r++)
    begin : g_pad_row
        for (genvar c = 0; c < pad_cols; c++)
        begin : g_pad_col
            if (r < pad || r >= pad + img_rows || c < pad || c >= pad + img_cols)
            begin : g_zero
                assign padded[r][c] = '0;
            end
            else
            begin : g_pix
                assign padded[r][c] = fr.image[(r - pad) * img_cols + (c - pad)];
            end
        end
    end

    // window n starts at padded row n/3, column n%3
    for (genvar n = 0; n < n_windows; n++)
    begin : g_win
        for (genvar k = 0; k < n_taps; k++)
        begin : g_tap
            assign windows[n][k] = padded[n / out_cols + k / flt_cols][n % out_cols + k % flt_cols];
        end

        conv conv_inst (
            .clk     (clk),
            .rst     (rst),
            .start   (start),
            .window  (windows[n]),
            .weights (fr.filter),
            .result  (unit_result[n]),
            .done    (unit_done[n])
        );
    end

    assign start          = fr.frame_valid && !busy && !results_valid;
    assign fr.frame_taken = results_valid && results_taken;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy          <= 1'b0;
            results_valid <= 1'b0;
        end
        else
        begin
            if (start)
                busy <= 1'b1;
            if (unit_done[0])  // all units finish together
            begin
                busy          <= 1'b0;
                results_valid <= 1'b1;
            end
            if (results_valid && results_taken)
                results_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (unit_done[0])
            results <= unit_result;
    end

endmodule

//--- verif/conv_engine_assert.sv
`timescale 1ns/1ps

module conv_engine_assert
    import conv_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic [cred_w-1:0] credits,
    input logic              out_valid,
    input logic              credit_return,
    input logic              results_valid,
    input logic              results_taken
);

    logic [cred_w:0] outstanding;  // results sent, credit not yet back

    always_ff @(posedge clk)
    begin
        if (rst)
            outstanding <= '0;
        else
            outstanding <= outstanding + {{cred_w{1'b0}}, out_valid}
                                       - {{cred_w{1'b0}}, credit_return};
    end

    // a wrap below zero also lands above the limit
    credit_range: assert property (@(posedge clk) disable iff (rst)
        credits <= cred_w'(out_credits))
        else $error("credit count %0d out of range", credits);

    credit_tracking: assert property (@(posedge clk) disable iff (rst)
        int'(credits) + int'(outstanding) == out_credits)
        else $error("credit count %0d disagrees with %0d outstanding", credits, outstanding);

    no_spend_without_credit: assert property (@(posedge clk) disable iff (rst)
        (outstanding == out_credits) |-> !out_valid)
        else $error("out_valid with every credit outstanding");

    results_hold: assert property (@(posedge clk) disable iff (rst)
        (results_valid && !results_taken) |=> results_valid)
        else $error("results_valid dropped before results_taken");

endmodule

bind result_drain conv_engine_assert conv_engine_assert_inst (
    .clk           (clk),
    .rst           (rst),
    .credits       (credits),
    .out_valid     (out_valid),
    .credit_return (credit_return),
    .results_valid (results_valid),
    .results_taken (results_taken)
);

//--- verif/tb_conv_engine.sv
`timescale 1ns/1ps

module tb_conv_engine
    import conv_pkg::*;
();

    localparam int clk_half        = 20;    // 40 ns clock
    localparam int reset_cycles    = 16;
    localparam int n_tests         = 6;
    localparam int cycles_per_test = 2000;
    localparam int wait_limit      = 400;   // per wait for outputs
    localparam int run_cycles      = 11;    // start edge to results_valid

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic [31:0]       in_word;
    logic              in_ready;
    logic              out_valid;
    logic [data_w-1:0] out_data;
    logic              credit_return;

    logic signed [data_w-1:0] img_m [img_pixels];  // model copy of the image
    logic signed [data_w-1:0] flt_m [n_taps];
    logic [data_w-1:0]        out_q [$];           // collected outputs
    logic [data_w-1:0]        exp_q [$];           // expected, in emission order
    longint                   due_q [$];           // cycles when credits go back

    integer seed         = 32'h5a813abb;
    int     errors       = 0;
    int     checks       = 0;
    int     cred_delay   = 3;
    bit     hold_credits = 1'b0;

    conv_engine_top conv_engine_top_inst (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_word       (in_word),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .credit_return (credit_return)
    );

    initial
    begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    initial
    begin
        repeat (reset_cycles + n_tests * cycles_per_test) @(posedge clk);
        $display("watchdog expired, tests did not finish within %0d cycles",
                 reset_cycles + n_tests * cycles_per_test);
        $display("TB FAILED");
        $finish;
    end

    // output collector and credit returner
    initial
    begin
        longint cyc;
        cyc           = 0;
        credit_return = 1'b0;
        forever
        begin
            @(negedge clk);
            cyc++;
            if (out_valid === 1'b1)
            begin
                out_q.push_back(out_data);
                due_q.push_back(cyc + longint'(cred_delay));
            end
            credit_return = 1'b0;
            if (!hold_credits && due_q.size() != 0 && due_q[0] <= cyc)
            begin
                credit_return = 1'b1;
                void'(due_q.pop_front());
            end
        end
    end

    // padded 3x3 convolution for window n, saturated to 16 bits
    function automatic logic [data_w-1:0] model_out(input int n);
        longint sum;
        int     pr;
        int     pc;
        sum = 0;
        for (int k = 0; k < n_taps; k++)
        begin
            pr = n / out_cols + k / flt_cols - pad;  // image row under tap k
            pc = n % out_cols + k % flt_cols - pad;
            if (pr >= 0 && pr < img_rows && pc >= 0 && pc < img_cols)
                sum += longint'(img_m[pr * img_cols + pc]) * longint'(flt_m[k]);
        end
        if (sum > 32767)
            return 16'h7fff;
        if (sum < -32768)
            return 16'h8000;
        return sum[data_w-1:0];
    endfunction

    function automatic logic [data_w-1:0] rand_sample(input bit big);
        logic [31:0]       r;
        logic [data_w-1:0] s;
        r = $random(seed);
        s = {{8{r[7]}}, r[7:0]};                     // moderate range
        if (big)
            s = {r[15], {3{~r[15]}}, r[11:0]};       // near full scale
        return s;
    endfunction

    task automatic send_word(input logic [31:0] w);
        while (!in_ready)
            @(negedge clk);
        in_valid = 1'b1;
        in_word  = w;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic load_image();
        logic [data_w-1:0] hi;
        send_word({op_image, 28'h0});
        for (int w = 0; w < int'(img_words); w++)
        begin
            hi = (2 * w + 1 < img_pixels) ? img_m[2 * w + 1] : '0;  // last half unused
            send_word({hi, img_m[2 * w]});
        end
    endtask

    task automatic load_filter();
        logic [data_w-1:0] hi;
        send_word({op_filter, 28'h0});
        for (int w = 0; w < int'(flt_words); w++)
        begin
            hi = (2 * w + 1 < n_taps) ? flt_m[2 * w + 1] : '0;
            send_word({hi, flt_m[2 * w]});
        end
    endtask

    task automatic start_run();
        for (int n = 0; n < n_windows; n++)
            exp_q.push_back(model_out(n));
        send_word({op_run, 28'h0});
    endtask

    task automatic wait_outputs(input int n);
        int cnt;
        cnt = 0;
        while (out_q.size() < n && cnt < wait_limit)
        begin
            @(negedge clk);
            cnt++;
        end
        if (out_q.size() < n)
        begin
            errors++;
            $display("timed out waiting for %0d results, only %0d arrived", n, out_q.size());
        end
    endtask

    task automatic check_outputs(input int n);
        logic [data_w-1:0] got;
        logic [data_w-1:0] exp_v;
        wait_outputs(n);
        for (int i = 0; i < n; i++)
        begin
            if (out_q.size() != 0)
            begin
                got   = out_q.pop_front();
                exp_v = exp_q.pop_front();
                checks++;
                if (got !== exp_v)
                begin
                    errors++;
                    $display("** Error: out_data result %0d got %h expected %h", i, got, exp_v);
                end
            end
        end
        exp_q.delete();
    endtask

    task automatic drain_credits();
        while (due_q.size() != 0)
            @(negedge clk);
        @(negedge clk);  // last return lands on the next edge
    endtask

    task automatic identity_filter();
        for (int i = 0; i < img_pixels; i++)
            img_m[i] = rand_sample(1'b0);
        for (int k = 0; k < n_taps; k++)
            flt_m[k] = '0;
        flt_m[n_taps / 2] = 16'sd1;  // centre tap only
        load_image();
        load_filter();
        start_run();
        check_outputs(n_windows);
    endtask

    task automatic ones_on_ramp();
        for (int i = 0; i < img_pixels; i++)
            img_m[i] = 16'(i + 1);
        for (int k = 0; k < n_taps; k++)
            flt_m[k] = 16'sd1;
        load_image();
        load_filter();
        start_run();
        check_outputs(n_windows);
    endtask

    task automatic saturation_extremes();
        int sat;
        sat = 0;
        for (int i = 0; i < img_pixels; i++)
            img_m[i] = rand_sample(1'b1);
        for (int k = 0; k < n_taps; k++)
            flt_m[k] = rand_sample(1'b1);
        for (int n = 0; n < n_windows; n++)
            if (model_out(n) == 16'h7fff || model_out(n) == 16'h8000)
                sat++;
        checks++;
        if (sat == 0)
        begin
            errors++;
            $display("random stimulus produced no saturated window");
        end
        load_image();
        load_filter();
        start_run();
        check_outputs(n_windows);
    endtask

    task automatic credit_backpressure();
        drain_credits();
        hold_credits = 1'b1;
        start_run();
        wait_outputs(out_credits);
        repeat (40) @(negedge clk);  // nothing more may leak out
        checks++;
        if (out_q.size() != out_credits)
        begin
            errors++;
            $display("** Error: out_valid pulses got %h expected %h", out_q.size(), out_credits);
        end
        hold_credits = 1'b0;
        check_outputs(n_windows);
    endtask

    task automatic back_to_back_frames();
        int low_cycles;
        low_cycles = 0;
        cred_delay = 6;
        for (int i = 0; i < img_pixels; i++)
            img_m[i] = rand_sample(1'b0);
        for (int k = 0; k < n_taps; k++)
            flt_m[k] = rand_sample(1'b0);
        load_image();
        load_filter();
        start_run();
        while (!in_ready)
        begin
            @(negedge clk);
            low_cycles++;
        end
        // one cycle to start, the run, then the handover to an empty drain
        checks++;
        if (low_cycles != run_cycles + 2)
        begin
            errors++;
            $display("** Error: in_ready low cycles got %h expected %h",
                     low_cycles, run_cycles + 2);
        end
        for (int k = 0; k < n_taps; k++)
            flt_m[k] = rand_sample(1'b0);
        load_filter();
        start_run();
        check_outputs(2 * n_windows);
        cred_delay = 3;
    endtask

    task automatic filter_only_reload();
        for (int k = 0; k < n_taps; k++)
            flt_m[k] = rand_sample(1'b0);
        load_filter();  // image stays from the previous frame
        start_run();
        check_outputs(n_windows);
    endtask

    initial
    begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_word  = '0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checks++;
        if (in_ready !== 1'b1 || out_valid !== 1'b0)
        begin
            errors++;
            $display("** Error: after reset in_ready %h out_valid %h", in_ready, out_valid);
        end
        identity_filter();
        ones_on_ramp();
        saturation_extremes();
        credit_backpressure();
        back_to_back_frames();
        filter_only_reload();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
